// File: hdl/stream_pkg.sv
// Shared definitions for the stream copy design
// Block and address widths with their types
// Control, status and identity word types and constants
// Source and destination region bases
// Copy engine state encoding
package stream_pkg;

  // --------------------
  // Widths and types
  localparam int DATA_W = 64;
  localparam int ADDR_W = 16;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [31:0] ctl_word_t;
  typedef logic [31:0] status_word_t;

  // Control word bit positions
  localparam int CTL_STREAM_BIT = 0;
  localparam int CTL_DEBUG_BIT = 31;

  // Regions are given in block units
  localparam addr_t SRC_BASE = 16'h0100;
  localparam addr_t DST_BASE = 16'h0800;

  localparam logic [15:0] STATUS_SIGNATURE = 16'hA111;
  localparam status_word_t CL_ID0 = 32'hF001_1D0F;

  // --------------------
  // Copy engine states
  typedef enum logic [2:0] {
    COPY_IDLE,
    COPY_READ_REQ,
    COPY_READ_DATA,
    COPY_WRITE,
    COPY_DONE
  } copy_state_t;

endpackage

// File: hdl/ctl_decode.sv
// Control word register and stream start decode
// Ownership sequencer for the memory port hand-over
// FLR acknowledge pulse generation
`timescale 1ns/1ps

module ctl_decode (
  input  logic                  clk,
  input  logic                  sync_rst_n,
  input  stream_pkg::ctl_word_t ctl0,
  input  logic                  flr_assert,
  input  logic                  finished,
  output stream_pkg::ctl_word_t ctl_q,
  output logic                  engine_start,
  output logic                  owner,
  output logic                  flr_done
);

  logic stream_q;
  logic stream_rise;
  logic flr_q;

  // --------------------
  // Control register
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      ctl_q <= '0;
      stream_q <= 1'b0;
    end
    else
    begin
      ctl_q <= ctl0;
      stream_q <= ctl_q[stream_pkg::CTL_STREAM_BIT];
    end
  end

  assign stream_rise = ctl_q[stream_pkg::CTL_STREAM_BIT] && !stream_q;

  // --------------------
  // Ownership sequencer
  // Restart pulse first, then the engine holds the port until it finishes
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      engine_start <= 1'b0;
      owner <= 1'b0;
    end
    else
    begin
      engine_start <= stream_rise && !owner;
      if (engine_start)
        owner <= 1'b1;
      else if (finished)
        owner <= 1'b0;
    end
  end

  // FLR acknowledge toggles while the request stays high
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      flr_q <= 1'b0;
      flr_done <= 1'b0;
    end
    else
    begin
      flr_q <= flr_assert;
      flr_done <= flr_q && !flr_done;
    end
  end

  // A restart only happens while the host owns the port
  assert property (@(posedge clk) disable iff (!sync_rst_n)
    engine_start |-> !owner)
    else $error("engine_start issued while the engine owns the port");

endmodule

// File: hdl/stream_copy_engine.sv
// Streaming copy engine
// Reads NUM_BLOCKS blocks from the source region and writes each one
// unchanged to the destination region, one transaction at a time
`timescale 1ns/1ps

module stream_copy_engine #(
  parameter int NUM_BLOCKS = 16
) (
  input  logic              clk,
  input  logic              sync_rst_n,
  input  logic              start,
  output logic              finished,
  output stream_pkg::addr_t eng_read_addr,
  output logic              eng_ar_valid,
  output stream_pkg::addr_t eng_ar_addr,
  input  logic              eng_ar_ready,
  input  logic              eng_r_valid,
  input  stream_pkg::data_t eng_r_data,
  output logic              eng_r_ready,
  output logic              eng_aw_valid,
  output stream_pkg::addr_t eng_aw_addr,
  input  logic              eng_aw_ready,
  output logic              eng_w_valid,
  output stream_pkg::data_t eng_w_data,
  input  logic              eng_w_ready
);

  localparam stream_pkg::addr_t LAST_IDX = stream_pkg::addr_t'(NUM_BLOCKS - 1);

  stream_pkg::copy_state_t state;
  stream_pkg::addr_t blk_idx;
  stream_pkg::data_t blk_data;
  logic aw_pend;
  logic w_pend;
  logic aw_done;
  logic w_done;

  // Each write channel completes on its own handshake
  assign aw_done = !aw_pend || eng_aw_ready;
  assign w_done = !w_pend || eng_w_ready;

  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      state <= stream_pkg::COPY_IDLE;
      blk_idx <= '0;
      aw_pend <= 1'b0;
      w_pend <= 1'b0;
    end
    else if (start)
    begin
      // Restart from any state
      state <= stream_pkg::COPY_READ_REQ;
      blk_idx <= '0;
      aw_pend <= 1'b0;
      w_pend <= 1'b0;
    end
    else
    begin
      case (state)
        stream_pkg::COPY_READ_REQ:
          if (eng_ar_ready)
            state <= stream_pkg::COPY_READ_DATA;
        stream_pkg::COPY_READ_DATA:
          if (eng_r_valid)
          begin
            aw_pend <= 1'b1;
            w_pend <= 1'b1;
            state <= stream_pkg::COPY_WRITE;
          end
        stream_pkg::COPY_WRITE:
        begin
          if (eng_aw_ready)
            aw_pend <= 1'b0;
          if (eng_w_ready)
            w_pend <= 1'b0;
          if (aw_done && w_done)
          begin
            blk_idx <= blk_idx + 1'b1;
            state <= (blk_idx == LAST_IDX) ? stream_pkg::COPY_DONE
                                           : stream_pkg::COPY_READ_REQ;
          end
        end
        default:
          state <= state;
      endcase
    end
  end

  // Block buffer between read and write
  always_ff @(posedge clk)
  begin
    if (state == stream_pkg::COPY_READ_DATA && eng_r_valid)
      blk_data <= eng_r_data;
  end

  assign eng_read_addr = stream_pkg::SRC_BASE + blk_idx;
  assign eng_ar_valid = (state == stream_pkg::COPY_READ_REQ);
  assign eng_ar_addr = eng_read_addr;
  assign eng_r_ready = (state == stream_pkg::COPY_READ_DATA);
  assign eng_aw_valid = aw_pend;
  assign eng_aw_addr = stream_pkg::DST_BASE + blk_idx;
  assign eng_w_valid = w_pend;
  assign eng_w_data = blk_data;
  assign finished = (state == stream_pkg::COPY_DONE);

  // Read request held stable under back-pressure
  assert property (@(posedge clk) disable iff (!sync_rst_n)
    eng_ar_valid && !eng_ar_ready && !start |=> eng_ar_valid && $stable(eng_ar_addr))
    else $error("ar request changed before it was accepted");

endmodule

// File: hdl/mem_port_mux.sv
// Memory port selector
// Routes requests of the current owner onto the memory port and
// blocks readies and responses towards the other side
`timescale 1ns/1ps

module mem_port_mux (
  input  logic              owner,
  input  logic              host_ar_valid,
  input  stream_pkg::addr_t host_ar_addr,
  output logic              host_ar_ready,
  output logic              host_r_valid,
  output stream_pkg::data_t host_r_data,
  input  logic              host_r_ready,
  input  logic              host_aw_valid,
  input  stream_pkg::addr_t host_aw_addr,
  output logic              host_aw_ready,
  input  logic              host_w_valid,
  input  stream_pkg::data_t host_w_data,
  output logic              host_w_ready,
  input  logic              eng_ar_valid,
  input  stream_pkg::addr_t eng_ar_addr,
  output logic              eng_ar_ready,
  output logic              eng_r_valid,
  output stream_pkg::data_t eng_r_data,
  input  logic              eng_r_ready,
  input  logic              eng_aw_valid,
  input  stream_pkg::addr_t eng_aw_addr,
  output logic              eng_aw_ready,
  input  logic              eng_w_valid,
  input  stream_pkg::data_t eng_w_data,
  output logic              eng_w_ready,
  output logic              mem_ar_valid,
  output stream_pkg::addr_t mem_ar_addr,
  input  logic              mem_ar_ready,
  input  logic              mem_r_valid,
  input  stream_pkg::data_t mem_r_data,
  output logic              mem_r_ready,
  output logic              mem_aw_valid,
  output stream_pkg::addr_t mem_aw_addr,
  input  logic              mem_aw_ready,
  output logic              mem_w_valid,
  output stream_pkg::data_t mem_w_data,
  input  logic              mem_w_ready
);

  // --------------------
  // Requests towards memory
  assign mem_ar_valid = owner ? eng_ar_valid : host_ar_valid;
  assign mem_ar_addr = owner ? eng_ar_addr : host_ar_addr;
  assign mem_r_ready = owner ? eng_r_ready : host_r_ready;
  assign mem_aw_valid = owner ? eng_aw_valid : host_aw_valid;
  assign mem_aw_addr = owner ? eng_aw_addr : host_aw_addr;
  assign mem_w_valid = owner ? eng_w_valid : host_w_valid;
  assign mem_w_data = owner ? eng_w_data : host_w_data;

  // --------------------
  // Readies and responses, held low for the side without the port
  assign host_ar_ready = !owner && mem_ar_ready;
  assign host_r_valid = !owner && mem_r_valid;
  assign host_aw_ready = !owner && mem_aw_ready;
  assign host_w_ready = !owner && mem_w_ready;
  assign eng_ar_ready = owner && mem_ar_ready;
  assign eng_r_valid = owner && mem_r_valid;
  assign eng_aw_ready = owner && mem_aw_ready;
  assign eng_w_ready = owner && mem_w_ready;

  // Read data goes to both sides, only the owner sees it valid
  assign host_r_data = mem_r_data;
  assign eng_r_data = mem_r_data;

endmodule

// File: hdl/status_result.sv
// Status and identity registers
// status0 packs signature, owner, done and memory ready
// id0 returns the fixed ID or the engine read address in debug mode
`timescale 1ns/1ps

module status_result (
  input  logic                     clk,
  input  logic                     sync_rst_n,
  input  stream_pkg::ctl_word_t    ctl_q,
  input  logic                     owner,
  input  logic                     finished,
  input  logic                     mem_is_ready,
  input  stream_pkg::addr_t        eng_read_addr,
  output stream_pkg::status_word_t status0,
  output stream_pkg::status_word_t id0
);

  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      status0 <= {stream_pkg::STATUS_SIGNATURE, 16'h0000};
      id0 <= stream_pkg::CL_ID0;
    end
    else
    begin
      // Bit 2 owner, bit 1 done, bit 0 memory ready
      status0 <= {stream_pkg::STATUS_SIGNATURE, 13'h0000, owner, finished, mem_is_ready};
      if (ctl_q[stream_pkg::CTL_DEBUG_BIT])
        id0 <= stream_pkg::status_word_t'(eng_read_addr);
      else
        id0 <= stream_pkg::CL_ID0;
    end
  end

endmodule

// File: hdl/cl_stream_top.sv
// Top level of the stream copy design
// Control decode, copy engine, memory port selector and status registers
`timescale 1ns/1ps

module cl_stream_top #(
  parameter int NUM_BLOCKS = 16
) (
  input  logic                     clk,
  input  logic                     sync_rst_n,
  input  stream_pkg::ctl_word_t    ctl0,
  input  logic                     mem_is_ready,
  input  logic                     flr_assert,
  output logic                     flr_done,
  output stream_pkg::status_word_t status0,
  output stream_pkg::status_word_t id0,
  // Host side
  input  logic                     host_ar_valid,
  input  stream_pkg::addr_t        host_ar_addr,
  output logic                     host_ar_ready,
  output logic                     host_r_valid,
  output stream_pkg::data_t        host_r_data,
  input  logic                     host_r_ready,
  input  logic                     host_aw_valid,
  input  stream_pkg::addr_t        host_aw_addr,
  output logic                     host_aw_ready,
  input  logic                     host_w_valid,
  input  stream_pkg::data_t        host_w_data,
  output logic                     host_w_ready,
  // Memory side
  output logic                     mem_ar_valid,
  output stream_pkg::addr_t        mem_ar_addr,
  input  logic                     mem_ar_ready,
  input  logic                     mem_r_valid,
  input  stream_pkg::data_t        mem_r_data,
  output logic                     mem_r_ready,
  output logic                     mem_aw_valid,
  output stream_pkg::addr_t        mem_aw_addr,
  input  logic                     mem_aw_ready,
  output logic                     mem_w_valid,
  output stream_pkg::data_t        mem_w_data,
  input  logic                     mem_w_ready
);

  // --------------------
  // Internal wires
  stream_pkg::ctl_word_t ctl_q;
  logic engine_start;
  logic owner;
  logic finished;
  stream_pkg::addr_t eng_read_addr;

  logic eng_ar_valid;
  stream_pkg::addr_t eng_ar_addr;
  logic eng_ar_ready;
  logic eng_r_valid;
  stream_pkg::data_t eng_r_data;
  logic eng_r_ready;
  logic eng_aw_valid;
  stream_pkg::addr_t eng_aw_addr;
  logic eng_aw_ready;
  logic eng_w_valid;
  stream_pkg::data_t eng_w_data;
  logic eng_w_ready;

  ctl_decode u_decode (
    .clk          (clk),
    .sync_rst_n   (sync_rst_n),
    .ctl0         (ctl0),
    .flr_assert   (flr_assert),
    .finished     (finished),
    .ctl_q        (ctl_q),
    .engine_start (engine_start),
    .owner        (owner),
    .flr_done     (flr_done)
  );

  stream_copy_engine #(
    .NUM_BLOCKS (NUM_BLOCKS)
  ) u_engine (
    .clk           (clk),
    .sync_rst_n    (sync_rst_n),
    .start         (engine_start),
    .finished      (finished),
    .eng_read_addr (eng_read_addr),
    .eng_ar_valid  (eng_ar_valid),
    .eng_ar_addr   (eng_ar_addr),
    .eng_ar_ready  (eng_ar_ready),
    .eng_r_valid   (eng_r_valid),
    .eng_r_data    (eng_r_data),
    .eng_r_ready   (eng_r_ready),
    .eng_aw_valid  (eng_aw_valid),
    .eng_aw_addr   (eng_aw_addr),
    .eng_aw_ready  (eng_aw_ready),
    .eng_w_valid   (eng_w_valid),
    .eng_w_data    (eng_w_data),
    .eng_w_ready   (eng_w_ready)
  );

  // Host, engine and memory signals share their names with the selector ports
  mem_port_mux u_mux (.*);

  status_result u_status (
    .clk           (clk),
    .sync_rst_n    (sync_rst_n),
    .ctl_q         (ctl_q),
    .owner         (owner),
    .finished      (finished),
    .mem_is_ready  (mem_is_ready),
    .eng_read_addr (eng_read_addr),
    .status0       (status0),
    .id0           (id0)
  );

endmodule

// File: bench/tb_mem_model.sv
// Memory model behind the memory port
// Single-beat read and write channels with LCG-driven ready stalls
// Whole memory preloaded with an address-dependent LCG pattern
`timescale 1ns/1ps

module tb_mem_model (
  input  logic              clk,
  input  logic              mem_ar_valid,
  input  stream_pkg::addr_t mem_ar_addr,
  output logic              mem_ar_ready,
  output logic              mem_r_valid,
  output stream_pkg::data_t mem_r_data,
  input  logic              mem_r_ready,
  input  logic              mem_aw_valid,
  input  stream_pkg::addr_t mem_aw_addr,
  output logic              mem_aw_ready,
  input  logic              mem_w_valid,
  input  stream_pkg::data_t mem_w_data,
  output logic              mem_w_ready
);

  localparam int DEPTH = 1 << stream_pkg::ADDR_W;

  stream_pkg::data_t mem [0:DEPTH-1];
  stream_pkg::addr_t rd_addr;
  stream_pkg::addr_t wr_addr;
  stream_pkg::data_t wr_data;
  logic [31:0] rnd;
  logic ar_fire;
  logic r_fire;
  logic aw_fire;
  logic w_fire;
  logic aw_have;
  logic w_have;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Two LCG steps seeded from the full address give one block
  function automatic stream_pkg::data_t fill_word(input stream_pkg::addr_t a);
    logic [31:0] s1;
    logic [31:0] s2;
    s1 = lcg_step(32'hb4a9 ^ {a, a});
    s2 = lcg_step(s1);
    return {s1, s2};
  endfunction

  initial
  begin
    rnd = 32'hb4a9;
    mem_ar_ready = 1'b0;
    mem_r_valid = 1'b0;
    mem_r_data = '0;
    mem_aw_ready = 1'b0;
    mem_w_ready = 1'b0;
    aw_have = 1'b0;
    w_have = 1'b0;
    rd_addr = '0;
    wr_addr = '0;
    wr_data = '0;
    for (int a = 0; a < DEPTH; a++)
      mem[a] = fill_word(stream_pkg::addr_t'(a));

    forever
    begin
      // --------------------
      // Handshakes seen at the edge
      @(posedge clk);
      ar_fire = mem_ar_valid && mem_ar_ready;
      r_fire = mem_r_valid && mem_r_ready;
      aw_fire = mem_aw_valid && mem_aw_ready;
      w_fire = mem_w_valid && mem_w_ready;
      rd_addr = mem_ar_addr;
      if (aw_fire)
        wr_addr = mem_aw_addr;
      if (w_fire)
        wr_data = mem_w_data;

      // --------------------
      // Responses and readies for the next cycle
      #1;
      if (r_fire)
        mem_r_valid = 1'b0;
      if (ar_fire)
      begin
        mem_r_valid = 1'b1;
        mem_r_data = mem[rd_addr];
      end
      aw_have = aw_have || aw_fire;
      w_have = w_have || w_fire;
      // Write commits once address and data are both in
      if (aw_have && w_have)
      begin
        mem[wr_addr] = wr_data;
        aw_have = 1'b0;
        w_have = 1'b0;
      end
      rnd = lcg_step(rnd);
      // One read in flight, so no new address while a response waits
      mem_ar_ready = !mem_r_valid && rnd[24];
      mem_aw_ready = !aw_have && rnd[26];
      mem_w_ready = !w_have && rnd[28];
    end
  end

endmodule

// File: bench/tb_cl_stream.sv
// Testbench for the stream copy top level
// Clock, reset, host traffic, copy run, FLR pulse and status checks
// Host read data compared against a reference of the copied blocks
`timescale 1ns/1ps

module tb_cl_stream;

  localparam int NUM_BLOCKS = 16;
  // Reset and host traffic need well under a hundred cycles, a block copy
  // about ten on average and rarely more than a hundred under stalls
  localparam int MAX_CYCLES = 4000;

  logic clk;
  logic sync_rst_n;
  stream_pkg::ctl_word_t ctl0;
  logic mem_is_ready;
  logic flr_assert;
  logic flr_done;
  stream_pkg::status_word_t status0;
  stream_pkg::status_word_t id0;
  logic host_ar_valid;
  stream_pkg::addr_t host_ar_addr;
  logic host_ar_ready;
  logic host_r_valid;
  stream_pkg::data_t host_r_data;
  logic host_r_ready;
  logic host_aw_valid;
  stream_pkg::addr_t host_aw_addr;
  logic host_aw_ready;
  logic host_w_valid;
  stream_pkg::data_t host_w_data;
  logic host_w_ready;
  logic mem_ar_valid;
  stream_pkg::addr_t mem_ar_addr;
  logic mem_ar_ready;
  logic mem_r_valid;
  stream_pkg::data_t mem_r_data;
  logic mem_r_ready;
  logic mem_aw_valid;
  stream_pkg::addr_t mem_aw_addr;
  logic mem_aw_ready;
  logic mem_w_valid;
  stream_pkg::data_t mem_w_data;
  logic mem_w_ready;

  stream_pkg::data_t expected_q[$];
  stream_pkg::data_t exp_data;
  int data_checks = 0;
  int data_errors = 0;
  int ctl_checks = 0;
  int ctl_errors = 0;
  int cycle_count = 0;

  // Port names match the signals above
  cl_stream_top #(
    .NUM_BLOCKS (NUM_BLOCKS)
  ) u_cl_stream_top (.*);

  tb_mem_model u_mem (.*);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------
  // Reference model
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Source block at an address, as preloaded behind the port
  function automatic stream_pkg::data_t source_block(input stream_pkg::addr_t a);
    logic [31:0] s1;
    logic [31:0] s2;
    s1 = lcg_step(32'hb4a9 ^ {a, a});
    s2 = lcg_step(s1);
    return {s1, s2};
  endfunction

  // Destination block idx after a copy equals source block idx
  function automatic stream_pkg::data_t ref_block(input int idx);
    return source_block(stream_pkg::SRC_BASE + stream_pkg::addr_t'(idx));
  endfunction

  // --------------------
  // Helpers
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    ctl_checks++;
    assert (got == want)
    else
    begin
      ctl_errors++;
      $display("Error: %s = 0x%h, expected 0x%h", name, got, want);
    end
  endtask

  // Each channel drops valid on its own once accepted
  task automatic host_write(input stream_pkg::addr_t addr, input stream_pkg::data_t data);
    logic aw_ok;
    logic w_ok;
    aw_ok = 1'b0;
    w_ok = 1'b0;
    host_aw_valid = 1'b1;
    host_aw_addr = addr;
    host_w_valid = 1'b1;
    host_w_data = data;
    while (!(aw_ok && w_ok))
    begin
      @(posedge clk);
      aw_ok = aw_ok || host_aw_ready;
      w_ok = w_ok || host_w_ready;
      #1;
      host_aw_valid = !aw_ok;
      host_w_valid = !w_ok;
    end
  endtask

  task automatic collect_read_data();
    host_r_ready = 1'b1;
    @(posedge clk);
    while (!host_r_valid)
      @(posedge clk);
    #1;
    host_r_ready = 1'b0;
  endtask

  task automatic host_read(input stream_pkg::addr_t addr, input stream_pkg::data_t want);
    expected_q.push_back(want);
    host_ar_valid = 1'b1;
    host_ar_addr = addr;
    @(posedge clk);
    while (!host_ar_ready)
      @(posedge clk);
    #1;
    host_ar_valid = 1'b0;
    collect_read_data();
  endtask

  task automatic finish_run(input logic timed_out);
    $display("Data checks %0d, data errors %0d, control checks %0d, control errors %0d",
             data_checks, data_errors, ctl_checks, ctl_errors);
    if (!timed_out && data_errors == 0 && ctl_errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  endtask

  // --------------------
  // Read data compare
  always @(posedge clk)
  begin
    if (host_r_valid && host_r_ready)
    begin
      data_checks++;
      if (expected_q.size() == 0)
      begin
        data_errors++;
        $display("Host read data arrived with no read outstanding");
      end
      else
      begin
        exp_data = expected_q.pop_front();
        assert (host_r_data == exp_data)
        else
        begin
          data_errors++;
          $display("Error: host_r_data = 0x%h, expected 0x%h", host_r_data, exp_data);
        end
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      finish_run(1'b1);
    end
  end

  // --------------------
  // Stimulus
  initial
  begin
    logic ready_q;
    ctl0 = '0;
    mem_is_ready = 1'b0;
    flr_assert = 1'b0;
    sync_rst_n = 1'b0;
    host_ar_valid = 1'b0;
    host_ar_addr = '0;
    host_r_ready = 1'b0;
    host_aw_valid = 1'b0;
    host_aw_addr = '0;
    host_w_valid = 1'b0;
    host_w_data = '0;
    ready_q = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    sync_rst_n = 1'b1;

    // Idle outputs after reset
    @(posedge clk);
    check_value("flr_done", 64'(flr_done), 64'd0);
    check_value("mem_ar_valid", 64'(mem_ar_valid), 64'd0);
    check_value("mem_aw_valid", 64'(mem_aw_valid), 64'd0);
    check_value("mem_w_valid", 64'(mem_w_valid), 64'd0);
    check_value("status0", 64'(status0), 64'({stream_pkg::STATUS_SIGNATURE, 16'h0000}));
    check_value("id0", 64'(id0), 64'(stream_pkg::CL_ID0));
    #1;
    mem_is_ready = 1'b1;
    repeat (2) @(posedge clk);
    // Signature on top, no owner, no done, memory ready in bit 0
    check_value("status0", 64'(status0), 64'({stream_pkg::STATUS_SIGNATURE, 16'h0001}));
    check_value("id0", 64'(id0), 64'(stream_pkg::CL_ID0));

    // Host owns the port
    #1;
    host_write(16'h0040, 64'h0123_4567_89ab_cdef);
    host_read(16'h0040, 64'h0123_4567_89ab_cdef);
    check_value("status0[2]", 64'(status0[2]), 64'd0);

    // One-cycle FLR request
    flr_assert = 1'b1;
    for (int k = 1; k <= 4; k++)
    begin
      @(posedge clk);
      check_value("flr_done", 64'(flr_done), 64'(k == 3));
      #1;
      flr_assert = 1'b0;
    end

    // --------------------
    // Copy run
    ctl0[stream_pkg::CTL_STREAM_BIT] = 1'b1;
    @(posedge clk);
    while (!status0[2])
      @(posedge clk);
    #1;
    host_ar_valid = 1'b1;
    host_ar_addr = stream_pkg::DST_BASE;
    expected_q.push_back(ref_block(0));
    @(posedge clk);
    ready_q = host_ar_ready;
    @(posedge clk);
    // status0 trails the ready path by one cycle
    while (status0[2])
    begin
      check_value("host_ar_ready", 64'(ready_q), 64'd0);
      ready_q = host_ar_ready;
      @(posedge clk);
    end
    check_value("status0[2:1]", 64'(status0[2:1]), 64'd1);
    if (!ready_q)
    begin
      while (!host_ar_ready)
        @(posedge clk);
    end
    #1;
    host_ar_valid = 1'b0;
    collect_read_data();
    for (int i = 1; i < NUM_BLOCKS; i++)
      host_read(stream_pkg::DST_BASE + stream_pkg::addr_t'(i), ref_block(i));

    // Debug readback of the engine read address
    ctl0[stream_pkg::CTL_DEBUG_BIT] = 1'b1;
    repeat (3) @(posedge clk);
    check_value("id0", 64'(id0),
                64'(stream_pkg::SRC_BASE + stream_pkg::addr_t'(NUM_BLOCKS)));

    #1;
    if (expected_q.size() != 0)
    begin
      ctl_errors++;
      $display("Some host reads never returned data");
    end
    finish_run(1'b0);
  end

endmodule

// File: all.f
hdl/stream_pkg.sv
hdl/ctl_decode.sv
hdl/stream_copy_engine.sv
hdl/mem_port_mux.sv
hdl/status_result.sv
hdl/cl_stream_top.sv
bench/tb_mem_model.sv
bench/tb_cl_stream.sv

// File: Makefile
# Verilator simulation of the stream copy design

VERILATOR ?= verilator
TOP       ?= tb_cl_stream
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= -Wno-fatal
PASS_TEXT := Verification passed

.PHONY: simulate clean

# Build, run, and succeed only when the pass line shows up in the output
simulate:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
